// File: flist.f
design/lc3b_pkg.sv
design/lc3b_fetch.sv
design/lc3b_decode.sv
design/lc3b_regfile.sv
design/lc3b_execute.sv
design/lc3b_result.sv
design/lc3b_core.sv
test/lc3b_checker.sv
test/lc3b_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -j 0 --top-module lc3b_tb -f flist.f -o lc3b_sim &&
{ ./obj_dir/lc3b_sim +verilator+error+limit+100 2>&1 | tee sim.log; } &&
grep -q "^NO ERRORS$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: test/lc3b_tb.sv
`timescale 1ns/1ps

module lc3b_tb;

    import lc3b_pkg::*;

    localparam int PROG_LEN   = 200;
    localparam int MAX_CYCLES = PROG_LEN * 12 + 100;

    logic       clk;
    logic       rst_n;
    logic       imem_req;
    lc3b_word   imem_addr;
    logic       imem_ack;
    lc3b_word   imem_data;
    logic       wb_valid;
    lc3b_reg    wb_reg;
    lc3b_word   wb_data;
    logic [2:0] wb_cc;

    lc3b_word prog [PROG_LEN];
    int       served;
    int       cycles;

    lc3b_core dut0 (.clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_data(imem_data), .wb_valid(wb_valid), .wb_reg(wb_reg),
        .wb_data(wb_data), .wb_cc(wb_cc));

    bind lc3b_core lc3b_checker chk0 (.clk(clk), .rst_n(rst_n), .imem_req(imem_req),
        .imem_ack(imem_ack), .imem_addr(imem_addr), .imem_data(imem_data),
        .id_valid(id_valid), .rd_a(rd_a), .rd_b(rd_b), .rd_a_data(rd_a_data),
        .rd_b_data(rd_b_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .wb_cc(wb_cc));

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Program table and memory responder
    // --------------------------------------------------

    // Kinds 0 to 4 are ADD, AND, NOT, SHF and LEA, 5 is the zero word, 6 an unknown opcode
    function automatic lc3b_word random_instr(int kind);
        lc3b_word w;
        w = lc3b_word'($urandom());
        case (kind)
            0, 1:
            begin
                w[15:12] = (kind == 0) ? OP_ADD : OP_AND;
                if (!w[5])
                    w[4:3] = 2'b00;             // Register form
            end
            2:
            begin
                w[15:12] = OP_NOT;
                w[5:0]   = 6'h3f;
            end
            3: w[15:12] = OP_SHF;
            4: w[15:12] = OP_LEA;
            5: w = 16'h0000;
            default:
                do
                    w[15:12] = lc3b_opcode'($urandom());
                while (w[15:12] inside {OP_ADD, OP_AND, OP_NOT, OP_SHF, OP_LEA});
        endcase
        return w;
    endfunction

    function automatic lc3b_word program_word(lc3b_word addr);
        int idx;
        idx = int'(addr[15:1]);
        return (idx < PROG_LEN) ? prog[idx] : 16'h0000;
    endfunction

    task automatic wait_cycles(int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic serve_fetch();
        wait_cycles(1 + int'($urandom_range(0, 3)));    // Memory registers imem_req first
        imem_data = program_word(imem_addr);
        imem_ack  = 1'b1;
        do
            wait_cycles(1);
        while (imem_req);
        wait_cycles(1 + int'($urandom_range(0, 3)));
        imem_ack = 1'b0;
        served++;
    endtask

    initial
    begin
        imem_ack  = 1'b0;
        imem_data = 16'h0000;
        served    = 0;
        forever
        begin
            wait_cycles(1);
            if (rst_n && imem_req && served < PROG_LEN)
                serve_fetch();
        end
    end

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------

    initial
    begin
        int seed_ret;
        seed_ret = $urandom(38382);
        rst_n    = 1'b0;
        for (int i = 0; i < PROG_LEN; i++)
            prog[i] = random_instr((i < 7) ? i : int'($urandom_range(0, 6)));
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (served == PROG_LEN);
        wait_cycles(6);                     // Last writeback lands four cycles after its fetch
        if (dut0.chk0.err_count != 0)
        begin
            $display("ERRORS FOUND");
            $fatal(1, "The checker reported a failing assertion");
        end
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial
    begin
        cycles = 0;
        while (dut0.chk0.err_count == 0 && cycles < MAX_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        $display("ERRORS FOUND");
        if (cycles >= MAX_CYCLES)
            $fatal(1, "Timeout with the program not finished after %0d cycles", cycles);
        else
            $fatal(1, "The checker reported a failing assertion at cycle %0d", cycles);
    end

endmodule : lc3b_tb

// File: test/lc3b_checker.sv
`timescale 1ns/1ps

module lc3b_checker
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               imem_req,
    input  logic               imem_ack,
    input  lc3b_pkg::lc3b_word imem_addr,
    input  lc3b_pkg::lc3b_word imem_data,
    input  logic               id_valid,
    input  lc3b_pkg::lc3b_reg  rd_a,
    input  lc3b_pkg::lc3b_reg  rd_b,
    input  lc3b_pkg::lc3b_word rd_a_data,
    input  lc3b_pkg::lc3b_word rd_b_data,
    input  logic               wb_valid,
    input  lc3b_pkg::lc3b_reg  wb_reg,
    input  lc3b_pkg::lc3b_word wb_data,
    input  logic [2:0]         wb_cc
);

    import lc3b_pkg::*;

    int         err_count = 0;
    lc3b_word   shadow [8];
    logic [2:0] shadow_cc;
    lc3b_word   cur_word;               // Last instruction handed over by memory
    lc3b_word   cur_pc;
    lc3b_word   next_addr;
    lc3b_word   va;
    lc3b_word   vb;
    lc3b_word   exp_data;
    logic [2:0] cc_after;
    logic       both_q;
    logic       hit;
    logic       hit_wr;

    assign hit    = imem_req && imem_ack && !both_q;
    assign hit_wr = hit && (imem_data != 16'h0000)
                    && (imem_data[15:12] inside {OP_ADD, OP_AND, OP_NOT, OP_SHF, OP_LEA});

    // --------------------------------------------------
    // Shadow model of the ISA
    // --------------------------------------------------

    always_comb
    begin
        va = shadow[cur_word[8:6]];
        vb = cur_word[5] ? {{11{cur_word[4]}}, cur_word[4:0]} : shadow[cur_word[2:0]];
        case (cur_word[15:12])
            OP_ADD:  exp_data = va + vb;
            OP_AND:  exp_data = va & vb;
            OP_NOT:  exp_data = ~va;
            OP_SHF:
                if (!cur_word[4])
                    exp_data = va << cur_word[3:0];
                else if (cur_word[5])
                    exp_data = lc3b_word'($signed(va) >>> cur_word[3:0]);
                else
                    exp_data = va >> cur_word[3:0];
            OP_LEA:  exp_data = cur_pc + 16'd2 + {{6{cur_word[8]}}, cur_word[8:0], 1'b0};
            default: exp_data = 16'h0000;
        endcase
        if (cur_word[15:12] == OP_LEA)
            cc_after = shadow_cc;           // LEA keeps N/Z/P
        else if (exp_data[15])
            cc_after = 3'b100;
        else if (exp_data == 16'h0000)
            cc_after = 3'b010;
        else
            cc_after = 3'b001;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            both_q    <= 1'b0;
            next_addr <= RESET_PC;
            cur_word  <= '0;
            cur_pc    <= '0;
            shadow_cc <= 3'b010;
            for (int i = 0; i < 8; i++)
                shadow[i] <= '0;
        end
        else
        begin
            both_q <= imem_req && imem_ack;
            if (hit)
            begin
                cur_word  <= imem_data;
                cur_pc    <= imem_addr;
                next_addr <= next_addr + 16'd2;
            end
            if (wb_valid)
            begin
                shadow[cur_word[11:9]] <= exp_data;
                shadow_cc              <= cc_after;
            end
        end
    end

    // --------------------------------------------------
    // Handshake and reset
    // --------------------------------------------------

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req && $stable(imem_addr))
    else
    begin
        err_count++;
        $error("imem_req fell or imem_addr moved before imem_ack rose");
    end

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !$past(imem_ack))
    else
    begin
        err_count++;
        $error("imem_req rose again while imem_ack was still high");
    end

    a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> imem_addr == next_addr)
    else
    begin
        err_count++;
        $error("Error imem_addr expected 0x%h got 0x%h", $sampled(next_addr), imem_addr);
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !imem_req && !wb_valid && wb_cc == 3'b010)
    else
    begin
        err_count++;
        $error("Outputs were not in their reset state when reset was released");
    end

    // --------------------------------------------------
    // Writeback
    // --------------------------------------------------

    a_wb_timing: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(hit_wr, 4))
    else
    begin
        err_count++;
        $error("Error wb_valid expected 0x%h got 0x%h", $past(hit_wr, 4), wb_valid);
    end

    a_wb_reg: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_reg == cur_word[11:9])
    else
    begin
        err_count++;
        $error("Error wb_reg expected 0x%h got 0x%h", $sampled(cur_word[11:9]), wb_reg);
    end

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_data == exp_data)
    else
    begin
        err_count++;
        $error("Error wb_data expected 0x%h got 0x%h", $sampled(exp_data), wb_data);
    end

    a_wb_cc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cc == (wb_valid ? cc_after : shadow_cc))
    else
    begin
        err_count++;
        $error("Error wb_cc expected 0x%h got 0x%h",
               $sampled(wb_valid ? cc_after : shadow_cc), wb_cc);
    end

    // Bubbles must leave the register file equal to the shadow copy
    a_rf_a: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |-> rd_a_data == shadow[rd_a])
    else
    begin
        err_count++;
        $error("Error rd_a_data expected 0x%h got 0x%h", $sampled(shadow[rd_a]), rd_a_data);
    end

    a_rf_b: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |-> rd_b_data == shadow[rd_b])
    else
    begin
        err_count++;
        $error("Error rd_b_data expected 0x%h got 0x%h", $sampled(shadow[rd_b]), rd_b_data);
    end

endmodule : lc3b_checker

// File: design/lc3b_core.sv
`timescale 1ns/1ps

module lc3b_core
(
    input  logic               clk,
    input  logic               rst_n,
    output logic               imem_req,
    output lc3b_pkg::lc3b_word imem_addr,
    input  logic               imem_ack,
    input  lc3b_pkg::lc3b_word imem_data,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_reg,
    output lc3b_pkg::lc3b_word wb_data,
    output logic [2:0]         wb_cc
);

    import lc3b_pkg::*;

    // --------------------------------------------------
    // Stage to stage wires
    // --------------------------------------------------

    logic     instr_valid;
    lc3b_word instr;
    lc3b_word instr_pc;

    logic     id_valid;
    lc3b_word id_pc;
    lc3b_reg  dest;
    lc3b_reg  src1;
    lc3b_reg  src2;
    lc3b_word imm5;
    lc3b_word imm4;
    lc3b_word offset9;
    lc3b_ctrl ctrl;

    lc3b_reg  rd_a;
    lc3b_reg  rd_b;
    lc3b_word rd_a_data;
    lc3b_word rd_b_data;

    logic     ex_valid;
    lc3b_reg  ex_dest;
    lc3b_word ex_result;
    lc3b_ctrl ex_ctrl;

    logic     wr_en;
    lc3b_reg  wr_reg;
    lc3b_word wr_data;

    // --------------------------------------------------
    // Stages
    // --------------------------------------------------

    lc3b_fetch fetch0 (.clk(clk), .rst_n(rst_n), .imem_ack(imem_ack), .imem_data(imem_data),
        .imem_req(imem_req), .imem_addr(imem_addr), .instr_valid(instr_valid),
        .instr(instr), .instr_pc(instr_pc));

    lc3b_decode decode0 (.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .id_valid(id_valid), .id_pc(id_pc), .dest(dest), .src1(src1),
        .src2(src2), .imm5(imm5), .imm4(imm4), .offset9(offset9), .ctrl(ctrl));

    lc3b_regfile regfile0 (.clk(clk), .rst_n(rst_n), .rd_a(rd_a), .rd_b(rd_b),
        .wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data));

    lc3b_execute execute0 (.clk(clk), .rst_n(rst_n), .id_valid(id_valid), .id_pc(id_pc),
        .dest(dest), .src1(src1), .src2(src2), .imm5(imm5), .imm4(imm4), .offset9(offset9),
        .ctrl(ctrl), .rd_a_data(rd_a_data), .rd_b_data(rd_b_data), .rd_a(rd_a), .rd_b(rd_b),
        .ex_valid(ex_valid), .ex_dest(ex_dest), .ex_result(ex_result), .ex_ctrl(ex_ctrl));

    lc3b_result result0 (.clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_dest(ex_dest),
        .ex_result(ex_result), .ex_ctrl(ex_ctrl), .wr_en(wr_en), .wr_reg(wr_reg),
        .wr_data(wr_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .wb_cc(wb_cc));

endmodule : lc3b_core

// File: design/lc3b_result.sv
`timescale 1ns/1ps

module lc3b_result
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_valid,
    input  lc3b_pkg::lc3b_reg  ex_dest,
    input  lc3b_pkg::lc3b_word ex_result,
    input  lc3b_pkg::lc3b_ctrl ex_ctrl,
    output logic               wr_en,
    output lc3b_pkg::lc3b_reg  wr_reg,
    output lc3b_pkg::lc3b_word wr_data,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_reg,
    output lc3b_pkg::lc3b_word wb_data,
    output logic [2:0]         wb_cc
);

    logic [2:0] cc_next;

    // The register file write lands on the same edge that raises wb_valid
    assign wr_en   = ex_valid & ex_ctrl.reg_write;
    assign wr_reg  = ex_dest;
    assign wr_data = ex_result;

    always_comb
    begin
        if (ex_result[15])
            cc_next = 3'b100;               // N
        else if (ex_result == 16'h0000)
            cc_next = 3'b010;               // Z
        else
            cc_next = 3'b001;               // P
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_valid <= 1'b0;
            wb_cc    <= 3'b010;
        end
        else
        begin
            wb_valid <= wr_en;
            if (ex_valid && ex_ctrl.set_cc)
                wb_cc <= cc_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            wb_reg  <= ex_dest;
            wb_data <= ex_result;
        end
    end

endmodule : lc3b_result

// File: design/lc3b_execute.sv
`timescale 1ns/1ps

module lc3b_execute
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               id_valid,
    input  lc3b_pkg::lc3b_word id_pc,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_reg  src1,
    input  lc3b_pkg::lc3b_reg  src2,
    input  lc3b_pkg::lc3b_word imm5,
    input  lc3b_pkg::lc3b_word imm4,
    input  lc3b_pkg::lc3b_word offset9,
    input  lc3b_pkg::lc3b_ctrl ctrl,
    input  lc3b_pkg::lc3b_word rd_a_data,
    input  lc3b_pkg::lc3b_word rd_b_data,
    output lc3b_pkg::lc3b_reg  rd_a,
    output lc3b_pkg::lc3b_reg  rd_b,
    output logic               ex_valid,
    output lc3b_pkg::lc3b_reg  ex_dest,
    output lc3b_pkg::lc3b_word ex_result,
    output lc3b_pkg::lc3b_ctrl ex_ctrl
);

    import lc3b_pkg::*;

    lc3b_word opb;
    lc3b_word alu_out;

    assign rd_a = src1;
    assign rd_b = src2;

    // --------------------------------------------------
    // Operand select and ALU
    // --------------------------------------------------

    always_comb
    begin
        if (!ctrl.use_imm)
            opb = rd_b_data;
        else if (ctrl.aluop inside {ALU_LSHF, ALU_RSHFL, ALU_RSHFA})
            opb = imm4;                     // Shift amount
        else
            opb = imm5;
    end

    always_comb
    begin
        case (ctrl.aluop)
            ALU_ADD:   alu_out = rd_a_data + opb;
            ALU_AND:   alu_out = rd_a_data & opb;
            ALU_NOT:   alu_out = ~rd_a_data;
            ALU_LSHF:  alu_out = rd_a_data << opb[3:0];
            ALU_RSHFL: alu_out = rd_a_data >> opb[3:0];
            ALU_RSHFA: alu_out = lc3b_word'($signed(rd_a_data) >>> opb[3:0]);
            ALU_PCREL: alu_out = id_pc + 16'd2 + offset9;
            default:   alu_out = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end
        else
        begin
            ex_valid <= id_valid;
            if (id_valid)
                ex_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk)
    begin
        if (id_valid)
        begin
            ex_dest   <= dest;
            ex_result <= alu_out;
        end
    end

endmodule : lc3b_execute

// File: design/lc3b_regfile.sv
`timescale 1ns/1ps

module lc3b_regfile
(
    input  logic               clk,
    input  logic               rst_n,
    input  lc3b_pkg::lc3b_reg  rd_a,
    input  lc3b_pkg::lc3b_reg  rd_b,
    input  logic               wr_en,
    input  lc3b_pkg::lc3b_reg  wr_reg,
    input  lc3b_pkg::lc3b_word wr_data,
    output lc3b_pkg::lc3b_word rd_a_data,
    output lc3b_pkg::lc3b_word rd_b_data
);

    import lc3b_pkg::*;

    lc3b_word regs [8];

    // Reads are asynchronous so execute sees operands in its own cycle
    assign rd_a_data = regs[rd_a];
    assign rd_b_data = regs[rd_b];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_reg] <= wr_data;
        end
    end

endmodule : lc3b_regfile

// File: design/lc3b_decode.sv
`timescale 1ns/1ps

module lc3b_decode
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  lc3b_pkg::lc3b_word instr,
    input  lc3b_pkg::lc3b_word instr_pc,
    output logic               id_valid,
    output lc3b_pkg::lc3b_word id_pc,
    output lc3b_pkg::lc3b_reg  dest,
    output lc3b_pkg::lc3b_reg  src1,
    output lc3b_pkg::lc3b_reg  src2,
    output lc3b_pkg::lc3b_word imm5,
    output lc3b_pkg::lc3b_word imm4,
    output lc3b_pkg::lc3b_word offset9,
    output lc3b_pkg::lc3b_ctrl ctrl
);

    import lc3b_pkg::*;

    lc3b_opcode opcode;
    lc3b_ctrl   ctrl_next;

    assign opcode = instr[15:12];

    // --------------------------------------------------
    // Control word generation
    // --------------------------------------------------

    always_comb
    begin
        ctrl_next = '0;
        if (instr != 16'h0000)              // The all-zero word stays a bubble
        begin
            case (opcode)
                OP_ADD, OP_AND:
                begin
                    ctrl_next.aluop     = (opcode == OP_ADD) ? ALU_ADD : ALU_AND;
                    ctrl_next.use_imm   = instr[5];
                    ctrl_next.reg_write = 1'b1;
                    ctrl_next.set_cc    = 1'b1;
                end
                OP_NOT:
                begin
                    ctrl_next.aluop     = ALU_NOT;
                    ctrl_next.reg_write = 1'b1;
                    ctrl_next.set_cc    = 1'b1;
                end
                OP_SHF:
                begin
                    // Bit 4 picks a right shift and bit 5 makes it arithmetic
                    case (instr[5:4])
                        2'b01:   ctrl_next.aluop = ALU_RSHFL;
                        2'b11:   ctrl_next.aluop = ALU_RSHFA;
                        default: ctrl_next.aluop = ALU_LSHF;
                    endcase
                    ctrl_next.use_imm   = 1'b1;
                    ctrl_next.reg_write = 1'b1;
                    ctrl_next.set_cc    = 1'b1;
                end
                OP_LEA:
                begin
                    ctrl_next.aluop     = ALU_PCREL;
                    ctrl_next.reg_write = 1'b1;      // LEA leaves N/Z/P alone
                end
                default:
                    ctrl_next = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // IF/ID latch
    // --------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            id_valid <= 1'b0;
            ctrl     <= '0;
        end
        else
        begin
            id_valid <= instr_valid;
            if (instr_valid)
                ctrl <= ctrl_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            id_pc   <= instr_pc;
            dest    <= instr[11:9];
            src1    <= instr[8:6];
            src2    <= instr[2:0];
            imm5    <= {{11{instr[4]}}, instr[4:0]};
            imm4    <= {12'h000, instr[3:0]};
            offset9 <= {{6{instr[8]}}, instr[8:0], 1'b0};
        end
    end

endmodule : lc3b_decode

// File: design/lc3b_fetch.sv
`timescale 1ns/1ps

module lc3b_fetch
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               imem_ack,
    input  lc3b_pkg::lc3b_word imem_data,
    output logic               imem_req,
    output lc3b_pkg::lc3b_word imem_addr,
    output logic               instr_valid,
    output lc3b_pkg::lc3b_word instr,
    output lc3b_pkg::lc3b_word instr_pc
);

    import lc3b_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } fetch_state_t;

    fetch_state_t state;
    lc3b_word     pc;
    logic         sample;

    assign imem_req  = (state == WAIT_ACK);    // Request is high only while waiting for ack
    assign imem_addr = pc;                     // PC only moves on the sample edge
    assign sample    = (state == WAIT_ACK) && imem_ack;

    // --------------------------------------------------
    // Four-phase handshake FSM
    // --------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            pc          <= RESET_PC;
            instr_valid <= 1'b0;
        end
        else
        begin
            instr_valid <= sample;
            case (state)
                IDLE:
                    if (!imem_ack)
                        state <= WAIT_ACK;
                WAIT_ACK:
                    if (imem_ack)
                    begin
                        state <= WAIT_RELEASE;
                        pc    <= pc + 16'd2;
                    end
                WAIT_RELEASE:
                    if (!imem_ack)                 // Memory has finished phase four
                        state <= WAIT_ACK;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Instruction word and its address are captured together
    always_ff @(posedge clk)
    begin
        if (sample)
        begin
            instr    <= imem_data;
            instr_pc <= pc;
        end
    end

endmodule : lc3b_fetch

// File: design/lc3b_pkg.sv
package lc3b_pkg;

    // --------------------------------------------------
    // Basic word types
    // --------------------------------------------------

    typedef logic [15:0] lc3b_word;     // Data and address word
    typedef logic [2:0]  lc3b_reg;      // Register index R0 to R7
    typedef logic [3:0]  lc3b_opcode;   // Instruction bits 15:12

    // --------------------------------------------------
    // Opcodes handled by the core
    // --------------------------------------------------

    localparam lc3b_opcode OP_ADD = 4'b0001;
    localparam lc3b_opcode OP_AND = 4'b0101;
    localparam lc3b_opcode OP_NOT = 4'b1001;
    localparam lc3b_opcode OP_SHF = 4'b1101;
    localparam lc3b_opcode OP_LEA = 4'b1110;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------

    typedef enum logic [2:0]
    {
        ALU_ADD   = 3'd0,
        ALU_AND   = 3'd1,
        ALU_NOT   = 3'd2,
        ALU_LSHF  = 3'd3,
        ALU_RSHFL = 3'd4,
        ALU_RSHFA = 3'd5,
        ALU_PCREL = 3'd6                // PC plus 2 plus offset9 for LEA
    } lc3b_aluop;

    // --------------------------------------------------
    // Control word carried down the pipe
    // --------------------------------------------------

    // An all-zero word is a bubble since reg_write and set_cc are both low
    typedef struct packed
    {
        lc3b_aluop aluop;
        logic      use_imm;             // Operand B comes from imm5 or imm4
        logic      reg_write;           // Result goes to the register file
        logic      set_cc;              // Result updates N/Z/P
    } lc3b_ctrl;

    // --------------------------------------------------
    // Reset state
    // --------------------------------------------------

    localparam lc3b_word RESET_PC = 16'h0000;

endpackage : lc3b_pkg
